// ==== build.f ====
dr_pkg.sv
dr_gate.sv
dr_full_adder.sv
dr_alu_word.sv
dr_sequencer.sv
dr_alu_top.sv
dr_alu_chk.sv
tb_dr_alu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dr_alu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+10

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_dr_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dr_alu import dr_pkg::*; ();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 16;
    localparam int num_req      = 200;
    localparam int drive_dly    = 2;
    localparam int watchdog_ns  = (num_req * 10 + reset_cycles) * clk_period;

    logic        clk = 1'b0;
    logic        reset;
    logic        start;
    alu_req_t    req;
    logic        busy;
    logic        done;
    alu_res_t    res;
    logic [15:0] lfsr = 16'd31;
    int          done_count;

    dr_alu_top DUT (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .res   (res)
    );

    always #(clk_period / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic draw_request(output alu_req_t r);
        logic [15:0] bits;
        take_bits(2, bits);
        r.op = alu_op_e'(bits[1:0]);
        take_bits(dr_width, bits);
        r.a = bits[dr_width-1:0];
        take_bits(dr_width, bits);
        r.b = bits[dr_width-1:0];
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #drive_dly;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            done_count <= 0;
        end else if (done) begin
            done_count <= done_count + 1;
        end
    end

    // Checker assertions bump a counter, seen half a cycle later
    always @(negedge clk) begin
        if (DUT.u_chk.error_count != 0) begin
            $display("TESTS FAILED");
            $fatal(1, "checker assertion failed");
        end
    end

    initial begin
        #(watchdog_ns);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired with %0d of %0d requests done", done_count, num_req);
    end

    initial begin
        alu_req_t    r;
        logic [15:0] bits;
        int          expect_done;
        reset       = 1'b1;
        start       = 1'b0;
        req         = '0;
        expect_done = 0;
        repeat (reset_cycles) @(posedge clk);
        #drive_dly;
        reset = 1'b0;

        for (int n = 0; n < num_req; n++) begin
            wait_idle();
            draw_request(r);
            req   = r;
            start = 1'b1;
            @(posedge clk);
            #drive_dly;
            start = 1'b0;
            expect_done++;

            // About one request in four also gets a start while running
            take_bits(2, bits);
            if (bits[1:0] == 2'd0 && busy) begin
                draw_request(r);
                req   = r;
                start = 1'b1;
                @(posedge clk);
                #drive_dly;
                start = 1'b0;
            end

            while (done_count < expect_done) begin
                @(posedge clk);
                #drive_dly;
            end
        end

        repeat (4) @(posedge clk);
        #drive_dly;
        if (DUT.u_chk.error_count == 0 && done_count == expect_done) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "%0d done pulses seen for %0d requests", done_count, expect_done);
        end
    end

endmodule

`default_nettype wire

// ==== dr_alu_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module dr_alu_chk import dr_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     start,
    input alu_req_t req,
    input logic     busy,
    input logic     done,
    input alu_res_t res
);

    alu_req_t acc_req;
    alu_res_t expected;
    alu_res_t res_q;
    logic     outstanding;
    logic     reset_q;
    logic     done_q;
    int       error_count = 0;

    // Reference result straight from the operation definitions
    function automatic alu_res_t model_result(input alu_req_t r);
        logic [dr_width:0] sum;
        alu_res_t          m;
        sum = {1'b0, r.a} + {1'b0, r.b};
        m.carry = 1'b0;
        case (r.op)
            op_and:  m.result = r.a & r.b;
            op_or:   m.result = r.a | r.b;
            op_xor:  m.result = r.a ^ r.b;
            default: begin
                m.result = sum[dr_width-1:0];
                m.carry  = sum[dr_width];
            end
        endcase
        return m;
    endfunction

    always_ff @(posedge clk) begin
        reset_q <= reset;
        done_q  <= done;
        res_q   <= res;
        if (reset) begin
            outstanding <= 1'b0;
            acc_req     <= '0;
        end else if (start && !busy) begin
            acc_req     <= req;
            outstanding <= 1'b1;
        end else if (done) begin
            outstanding <= 1'b0;
        end
    end

    assign expected = model_result(acc_req);

    a_reset: assert property (@(posedge clk) reset_q && !reset |-> !busy && !done && res == '0)
        else begin
            $error("CHECK FAILED t=%0t busy/done/res expected 0/0/000 actual %b/%b/%h",
                   $time, busy, done, res);
            error_count++;
        end

    a_result: assert property (@(posedge clk) disable iff (reset) done |-> res == expected)
        else begin
            $error("CHECK FAILED t=%0t res expected %h actual %h", $time, expected, res);
            error_count++;
        end

    a_busy_rise: assert property (@(posedge clk) disable iff (reset) start && !busy |=> busy)
        else begin
            $error("CHECK FAILED t=%0t busy expected 1 actual %b", $time, busy);
            error_count++;
        end

    a_busy_hold: assert property (@(posedge clk) disable iff (reset) busy && !done |=> busy)
        else begin
            $error("CHECK FAILED t=%0t busy expected 1 actual %b", $time, busy);
            error_count++;
        end

    // One done per accepted start, never a stray one
    a_one_done: assert property (@(posedge clk) disable iff (reset) done |-> outstanding && busy)
        else begin
            $error("CHECK FAILED t=%0t done without a running request, busy %b", $time, busy);
            error_count++;
        end

    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
                                   start && !busy |-> !outstanding)
        else begin
            $error("CHECK FAILED t=%0t start accepted before the previous done", $time);
            error_count++;
        end

    a_res_hold: assert property (@(posedge clk) disable iff (reset) !done |-> res == res_q)
        else begin
            $error("CHECK FAILED t=%0t res expected %h actual %h", $time, res_q, res);
            error_count++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |-> !done_q)
        else begin
            $error("CHECK FAILED t=%0t done expected 0 actual %b", $time, done);
            error_count++;
        end

endmodule

bind dr_alu_top dr_alu_chk u_chk (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .req   (req),
    .busy  (busy),
    .done  (done),
    .res   (res)
);

`default_nettype wire

// ==== dr_alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dr_alu_top import dr_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  alu_req_t req,
    output logic     busy,
    output logic     done,
    output alu_res_t res
);

    dr_dp_in_t  dp_in;
    dr_dp_out_t dp_out;

    // Clocked four-phase controller
    dr_sequencer u_seq (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .res    (res),
        .dp_in  (dp_in),
        .dp_out (dp_out)
    );

    // Self-timed dual-rail datapath
    dr_alu_word u_word (
        .dp_in  (dp_in),
        .dp_out (dp_out)
    );

endmodule

`default_nettype wire

// ==== dr_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dr_sequencer import dr_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  alu_req_t   req,
    output logic       busy,
    output logic       done,
    output alu_res_t   res,
    output dr_dp_in_t  dp_in,
    input  dr_dp_out_t dp_out
);

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_spacer
    } state_e;

    state_e                state;
    alu_req_t              req_q;
    alu_res_t              cap;
    dr_bit_t [dr_width:0]  pairs;
    logic                  dp_complete;
    logic                  dp_null;

    function automatic dr_bit_t to_rail(input logic v);
        return '{rail_t: v, rail_f: ~v};
    endfunction

    // Spacer everywhere except in the data phase
    always_comb begin
        dp_in = '0;
        if (state == st_data) begin
            dp_in.op[0] = to_rail(req_q.op[0]);
            dp_in.op[1] = to_rail(req_q.op[1]);
            for (int i = 0; i < dr_width; i++) begin
                dp_in.a[i] = to_rail(req_q.a[i]);
                dp_in.b[i] = to_rail(req_q.b[i]);
            end
        end
    end

    // Result and carry rail pairs lie side by side
    assign pairs = dp_out;

    always_comb begin
        dp_complete = 1'b1;
        dp_null     = 1'b1;
        for (int i = 0; i <= dr_width; i++) begin
            dp_complete &= pairs[i].rail_t ^ pairs[i].rail_f;
            dp_null     &= ~(pairs[i].rail_t | pairs[i].rail_f);
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) req_q <= req;
        // True rails carry the single-rail value once complete
        if (state == st_data && dp_complete) begin
            for (int i = 0; i < dr_width; i++) begin
                cap.result[i] <= dp_out.result[i].rail_t;
            end
            cap.carry <= dp_out.carry.rail_t;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            busy  <= 1'b0;
            done  <= 1'b0;
            res   <= '0;
        end else begin
            done <= 1'b0;
            if (done) busy <= 1'b0;
            case (state)
                st_idle: begin
                    if (start && !busy) begin
                        state <= st_data;
                        busy  <= 1'b1;
                    end
                end
                st_data: begin
                    if (dp_complete) state <= st_spacer;
                end
                st_spacer: begin
                    // Wait for the whole datapath to drain before reporting
                    if (dp_null) begin
                        state <= st_idle;
                        done  <= 1'b1;
                        res   <= cap;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dr_alu_word.sv ====
`timescale 1ns/1ps
`default_nettype none

module dr_alu_word import dr_pkg::*; (
    input  dr_dp_in_t  dp_in,
    output dr_dp_out_t dp_out
);

    dr_word_t and_w;
    dr_word_t or_w;
    dr_word_t xor_w;
    dr_word_t sum_w;
    dr_bit_t  carry [dr_width+1];
    dr_op_t   op_n;

    // Inverted selects are plain rail swaps
    assign op_n[0] = '{rail_t: dp_in.op[0].rail_f, rail_f: dp_in.op[0].rail_t};
    assign op_n[1] = '{rail_t: dp_in.op[1].rail_f, rail_f: dp_in.op[1].rail_t};

    assign carry[0] = dr_zero;

    for (genvar i = 0; i < dr_width; i++) begin : g_bit
        dr_gate #(.fn(fn_and)) u_and (.a(dp_in.a[i]), .b(dp_in.b[i]), .y(and_w[i]));
        dr_gate #(.fn(fn_or))  u_or  (.a(dp_in.a[i]), .b(dp_in.b[i]), .y(or_w[i]));
        dr_gate #(.fn(fn_xor)) u_xor (.a(dp_in.a[i]), .b(dp_in.b[i]), .y(xor_w[i]));

        dr_full_adder u_fa (
            .a    (dp_in.a[i]),
            .b    (dp_in.b[i]),
            .cin  (carry[i]),
            .sum  (sum_w[i]),
            .cout (carry[i+1])
        );
    end

    // One 4:1 mux per result bit plus one for the carry column.
    // Slots 0..3 hold the candidates in op order, 4..6 the mux nodes.
    for (genvar c = 0; c <= dr_width; c++) begin : g_col
        dr_bit_t node [7];

        if (c < dr_width) begin : g_data
            assign node[0] = and_w[c];
            assign node[1] = or_w[c];
            assign node[2] = xor_w[c];
            assign node[3] = sum_w[c];
            assign dp_out.result[c] = node[6];
        end else begin : g_carry
            // Carry is only meaningful for add
            assign node[0] = dr_zero;
            assign node[1] = dr_zero;
            assign node[2] = dr_zero;
            assign node[3] = carry[dr_width];
            assign dp_out.carry = node[6];
        end

        for (genvar k = 0; k < 3; k++) begin : g_mux
            dr_bit_t lo;
            dr_bit_t hi;

            dr_gate #(.fn(fn_and)) u_lo (.a(op_n[k/2]), .b(node[2*k]), .y(lo));
            dr_gate #(.fn(fn_and)) u_hi (.a(dp_in.op[k/2]), .b(node[2*k+1]), .y(hi));
            dr_gate #(.fn(fn_or))  u_or (.a(lo), .b(hi), .y(node[4+k]));
        end
    end

endmodule

`default_nettype wire

// ==== dr_full_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module dr_full_adder import dr_pkg::*; (
    input  dr_bit_t a,
    input  dr_bit_t b,
    input  dr_bit_t cin,
    output dr_bit_t sum,
    output dr_bit_t cout
);

    dr_bit_t prop;
    dr_bit_t gen;
    dr_bit_t pass;

    // Half adder on the operands
    dr_gate #(.fn(fn_xor)) u_prop (.a(a), .b(b), .y(prop));
    dr_gate #(.fn(fn_and)) u_gen  (.a(a), .b(b), .y(gen));

    // Second half adder folds in the carry
    dr_gate #(.fn(fn_xor)) u_sum  (.a(prop), .b(cin), .y(sum));
    dr_gate #(.fn(fn_and)) u_pass (.a(prop), .b(cin), .y(pass));

    // Majority of a, b and cin
    dr_gate #(.fn(fn_or))  u_cout (.a(gen), .b(pass), .y(cout));

endmodule

`default_nettype wire

// ==== dr_gate.sv ====
`timescale 1ns/1ps
`default_nettype none

module dr_gate import dr_pkg::*; #(
    parameter gate_fn_e fn = fn_and
) (
    input  dr_bit_t a,
    input  dr_bit_t b,
    output dr_bit_t y
);

    logic complete;
    logic onset;
    logic offset;

    // Both inputs must carry data before either output rail may rise
    assign complete = (a.rail_t | a.rail_f) & (b.rail_t | b.rail_f);

    always_comb begin
        case (fn)
            fn_and: begin
                onset  = a.rail_t & b.rail_t;
                offset = a.rail_f | b.rail_f;
            end
            fn_or: begin
                onset  = a.rail_t | b.rail_t;
                offset = a.rail_f & b.rail_f;
            end
            fn_xor: begin
                onset  = (a.rail_t & b.rail_f) | (a.rail_f & b.rail_t);
                offset = (a.rail_t & b.rail_t) | (a.rail_f & b.rail_f);
            end
            default: begin
                onset  = 1'b0;
                offset = 1'b0;
            end
        endcase
    end

    // Output falls back to NULL as soon as one input is a spacer
    assign y.rail_t = complete & onset;
    assign y.rail_f = complete & offset;

endmodule

`default_nettype wire

// ==== dr_pkg.sv ====
`default_nettype none

package dr_pkg;

    // Data word width of the datapath
    localparam int dr_width = 8;

    // One dual-rail bit, 00 is the spacer and 11 is illegal
    typedef struct packed {
        logic rail_t;
        logic rail_f;
    } dr_bit_t;

    // Valid logic zero, used for the carry-in and unused mux legs
    localparam dr_bit_t dr_zero = '{rail_t: 1'b0, rail_f: 1'b1};

    typedef dr_bit_t [dr_width-1:0] dr_word_t;

    typedef enum logic [1:0] {
        op_and = 2'd0,
        op_or  = 2'd1,
        op_xor = 2'd2,
        op_add = 2'd3
    } alu_op_e;

    // Op code in dual-rail form, bit 0 steers the first mux level
    typedef dr_bit_t [1:0] dr_op_t;

    typedef enum logic [1:0] {
        fn_and = 2'd0,
        fn_or  = 2'd1,
        fn_xor = 2'd2
    } gate_fn_e;

    typedef struct packed {
        alu_op_e             op;
        logic [dr_width-1:0] a;
        logic [dr_width-1:0] b;
    } alu_req_t;

    typedef struct packed {
        logic [dr_width-1:0] result;
        logic                carry;
    } alu_res_t;

    typedef struct packed {
        dr_op_t   op;
        dr_word_t a;
        dr_word_t b;
    } dr_dp_in_t;

    typedef struct packed {
        dr_word_t result;
        dr_bit_t  carry;
    } dr_dp_out_t;

endpackage

`default_nettype wire
